/* Bender.yml */
package:
  name: csidh_scheduler

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/csidhPkg.sv
      - hdl/scaleIf.sv
      - hdl/selectIf.sv
      - hdl/exponentBank.sv
      - hdl/wordSerialScaler.sv
      - hdl/batchSelector.sv
      - hdl/roundControl.sv
      - hdl/csidhScheduler.sv
  - target: test
    files:
      - test/csidhSchedulerTb.sv

/* hdl/batchSelector.sv */
`timescale 1ns/1ps
`include "csidh_macros.svh"

module batchSelector import csidhPkg::*; (
	input  logic clk,
	input  logic rst,
	selectIf.unit sel,
	output primeIndex_t readIndex,
	input  expCode_t readCode
);

	localparam primeIndex_t LastIndex = primeIndex_t'(`CSIDH_NUM_PRIMES - 1);
	localparam batchCount_t LastSlot = batchCount_t'(`CSIDH_BATCH_MAX - 1);

	selState_t state;
	primeIndex_t index;
	batchCount_t count;
	primeMask_t mask;
	logic negative;
	logic doneReg;
	logic hit;

	// right direction and something left to spend
	assign hit = (readCode[signBit] == negative) && (readCode[signBit-1:0] != '0);
	assign readIndex = index;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= selIdle;
			index <= '0;
			count <= '0;
			doneReg <= 1'b0;
		end else begin
			doneReg <= 1'b0;
			case (state)
				selIdle: begin
					if (sel.start) begin
						index <= '0;
						count <= '0;
						state <= selScan;
					end
				end
				selScan: begin
					if (hit) begin
						count <= count + 1'b1;
					end
					// stop at the table end or on the last free slot
					if ((index == LastIndex) || (hit && (count == LastSlot))) begin
						doneReg <= 1'b1;
						state <= selIdle;
					end else begin
						index <= index + 1'b1;
					end
				end
				default: state <= selIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == selIdle && sel.start) begin
			mask <= '0;
			negative <= sel.negative;
		end else if (state == selScan && hit) begin
			mask[index] <= 1'b1;
		end
	end

	assign sel.mask = mask;
	assign sel.done = doneReg;
	assign sel.empty = (count == '0);

endmodule

/* hdl/csidhPkg.sv */
`include "csidh_macros.svh"

package csidhPkg;

	// --------------------
	// vector types
	// --------------------
	typedef logic [`CSIDH_N-1:0] fieldWord_t;
	typedef logic [`CSIDH_LIMB-1:0] limb_t;
	typedef logic [`CSIDH_PRIME_BITS-1:0] smallPrime_t;
	// sign on top, set for the twist direction
	typedef logic [`CSIDH_EXP_BITS-1:0] expCode_t;
	typedef logic [6:0] primeIndex_t;
	typedef logic [`CSIDH_NUM_PRIMES-1:0] primeMask_t;
	typedef logic [4:0] batchCount_t;
	typedef logic [`CSIDH_KEY_BITS-1:0] privateKey_t;

	localparam int signBit = `CSIDH_EXP_BITS - 1;

	// --------------------
	// state machines
	// --------------------
	typedef enum logic [2:0] {
		ctrlIdle,
		ctrlSelect,
		ctrlSelWait,
		ctrlScan,
		ctrlMulWait,
		ctrlOffer,
		ctrlFinish
	} ctrlState_t;

	typedef enum logic {
		selIdle,
		selScan
	} selState_t;

	// small primes, ascending, 587 last
	localparam smallPrime_t primeTable [`CSIDH_NUM_PRIMES] = '{
		12'd3,   12'd5,   12'd7,   12'd11,  12'd13,  12'd17,  12'd19,  12'd23,
		12'd29,  12'd31,  12'd37,  12'd41,  12'd43,  12'd47,  12'd53,  12'd59,
		12'd61,  12'd67,  12'd71,  12'd73,  12'd79,  12'd83,  12'd89,  12'd97,
		12'd101, 12'd103, 12'd107, 12'd109, 12'd113, 12'd127, 12'd131, 12'd137,
		12'd139, 12'd149, 12'd151, 12'd157, 12'd163, 12'd167, 12'd173, 12'd179,
		12'd181, 12'd191, 12'd193, 12'd197, 12'd199, 12'd211, 12'd223, 12'd227,
		12'd229, 12'd233, 12'd239, 12'd241, 12'd251, 12'd257, 12'd263, 12'd269,
		12'd271, 12'd277, 12'd281, 12'd283, 12'd293, 12'd307, 12'd311, 12'd313,
		12'd317, 12'd331, 12'd337, 12'd347, 12'd349, 12'd353, 12'd359, 12'd367,
		12'd373, 12'd587
	};

endpackage

/* hdl/csidhScheduler.sv */
`timescale 1ns/1ps

module csidhScheduler import csidhPkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  privateKey_t privateKey,
	output logic batchValid,
	input  logic batchReady,
	input  primeMask_t resultMask,
	output primeMask_t batchMask,
	output fieldWord_t batchScalar,
	output logic batchNegative,
	output logic busy,
	output logic done
);

	scaleIf scaleBus ();
	selectIf selBus ();

	logic load;
	logic apply;
	primeMask_t applyMask;
	primeIndex_t readIndex;
	expCode_t readCode;

	exponentBank exponentBank_i (
		.clk(clk),
		.rst(rst),
		.load(load),
		.privateKey(privateKey),
		.readIndex(readIndex),
		.readCode(readCode),
		.applyMask(applyMask),
		.apply(apply)
	);

	wordSerialScaler wordSerialScaler_i (
		.clk(clk),
		.rst(rst),
		.scale(scaleBus.unit)
	);

	batchSelector batchSelector_i (
		.clk(clk),
		.rst(rst),
		.sel(selBus.unit),
		.readIndex(readIndex),
		.readCode(readCode)
	);

	roundControl roundControl_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.privateKey(privateKey),
		.load(load),
		.apply(apply),
		.applyMask(applyMask),
		.sel(selBus.ctrl),
		.scale(scaleBus.ctrl),
		.batchValid(batchValid),
		.batchReady(batchReady),
		.resultMask(resultMask),
		.batchMask(batchMask),
		.batchScalar(batchScalar),
		.batchNegative(batchNegative),
		.busy(busy),
		.done(done)
	);

endmodule

/* hdl/csidh_macros.svh */
`ifndef CSIDH_MACROS_SVH
`define CSIDH_MACROS_SVH

// --------------------
// field and scaler
// --------------------
`define CSIDH_N 512
`define CSIDH_LIMB 32

// --------------------
// key and batching
// --------------------
`define CSIDH_NUM_PRIMES 74
`define CSIDH_BATCH_MAX 16
`define CSIDH_EXP_BITS 4
`define CSIDH_PRIME_BITS 12
`define CSIDH_KEY_BITS 296

`endif

/* hdl/exponentBank.sv */
`timescale 1ns/1ps
`include "csidh_macros.svh"

module exponentBank import csidhPkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  privateKey_t privateKey,
	input  primeIndex_t readIndex,
	output expCode_t readCode,
	input  primeMask_t applyMask,
	input  logic apply
);

	expCode_t codes [`CSIDH_NUM_PRIMES];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CSIDH_NUM_PRIMES; i++) begin
				codes[i] <= '0;
			end
		end else if (load) begin
			// prime 0 sits in the top nibble
			for (int i = 0; i < `CSIDH_NUM_PRIMES; i++) begin
				codes[i] <= privateKey[`CSIDH_EXP_BITS*(`CSIDH_NUM_PRIMES-1-i) +: `CSIDH_EXP_BITS];
			end
		end else if (apply) begin
			for (int i = 0; i < `CSIDH_NUM_PRIMES; i++) begin
				// magnitude only, sign kept
				if (applyMask[i] && (codes[i][signBit-1:0] != '0)) begin
					codes[i] <= {codes[i][signBit], codes[i][signBit-1:0] - 1'b1};
				end
			end
		end
	end

	assign readCode = (readIndex < `CSIDH_NUM_PRIMES) ? codes[readIndex] : '0;

endmodule

/* hdl/roundControl.sv */
`timescale 1ns/1ps
`include "csidh_macros.svh"

module roundControl import csidhPkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  privateKey_t privateKey,
	output logic load,
	output logic apply,
	output primeMask_t applyMask,
	selectIf.ctrl sel,
	scaleIf.ctrl scale,
	output logic batchValid,
	input  logic batchReady,
	input  primeMask_t resultMask,
	output primeMask_t batchMask,
	output fieldWord_t batchScalar,
	output logic batchNegative,
	output logic busy,
	output logic done
);

	localparam primeIndex_t LastIndex = primeIndex_t'(`CSIDH_NUM_PRIMES - 1);

	ctrlState_t state;
	primeIndex_t primeIdx;
	fieldWord_t scalar;
	logic negative;
	logic keyActive;
	logic inBatch;
	logic transfer;

	// any nonzero magnitude in the incoming key
	always_comb begin
		keyActive = 1'b0;
		for (int i = 0; i < `CSIDH_NUM_PRIMES; i++) begin
			keyActive = keyActive | (|privateKey[`CSIDH_EXP_BITS*i +: signBit]);
		end
	end

	assign inBatch = sel.mask[primeIdx];
	assign transfer = (state == ctrlOffer) && batchReady;

	assign load = start && (state == ctrlIdle);
	assign sel.start = (state == ctrlSelect);
	assign sel.negative = negative;
	assign scale.start = (state == ctrlScan) && !inBatch;
	assign scale.operand = scalar;
	assign scale.factor = primeTable[primeIdx];

	assign batchValid = (state == ctrlOffer);
	assign batchMask = sel.mask;
	assign batchScalar = scalar;
	assign batchNegative = negative;
	assign busy = (state != ctrlIdle);

	// --------------------
	// round FSM
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ctrlIdle;
			primeIdx <= '0;
			negative <= 1'b0;
			apply <= 1'b0;
			done <= 1'b0;
		end else begin
			apply <= 1'b0;
			case (state)
				ctrlIdle: begin
					if (start) begin
						done <= 1'b0;
						negative <= 1'b0;
						state <= keyActive ? ctrlSelect : ctrlFinish;
					end
				end
				ctrlSelect: state <= ctrlSelWait;
				ctrlSelWait: begin
					if (sel.done) begin
						if (!sel.empty) begin
							primeIdx <= '0;
							state <= ctrlScan;
						end else if (!negative) begin
							// positive side exhausted, twist side from now on
							negative <= 1'b1;
							state <= ctrlSelect;
						end else begin
							state <= ctrlFinish;
						end
					end
				end
				ctrlScan: begin
					if (!inBatch) begin
						state <= ctrlMulWait;
					end else if (primeIdx == LastIndex) begin
						state <= ctrlOffer;
					end else begin
						primeIdx <= primeIdx + 1'b1;
					end
				end
				ctrlMulWait: begin
					if (scale.done) begin
						if (primeIdx == LastIndex) begin
							state <= ctrlOffer;
						end else begin
							primeIdx <= primeIdx + 1'b1;
							state <= ctrlScan;
						end
					end
				end
				ctrlOffer: begin
					if (batchReady) begin
						apply <= 1'b1;
						state <= ctrlSelect;
					end
				end
				ctrlFinish: begin
					done <= 1'b1;
					state <= ctrlIdle;
				end
				default: state <= ctrlIdle;
			endcase
		end
	end

	// scalar k and decrement mask
	always_ff @(posedge clk) begin
		if (state == ctrlSelWait && sel.done) begin
			scalar <= fieldWord_t'(4);
		end else if (state == ctrlMulWait && scale.done) begin
			scalar <= scale.product;
		end
		if (transfer) begin
			applyMask <= sel.mask & resultMask;
		end
	end

endmodule

/* hdl/scaleIf.sv */
`timescale 1ns/1ps

interface scaleIf import csidhPkg::*; ();

	logic start;
	fieldWord_t operand;
	smallPrime_t factor;
	fieldWord_t product;
	logic done;

	modport ctrl (
		output start,
		output operand,
		output factor,
		input  product,
		input  done
	);

	modport unit (
		input  start,
		input  operand,
		input  factor,
		output product,
		output done
	);

endinterface

/* hdl/selectIf.sv */
`timescale 1ns/1ps

interface selectIf import csidhPkg::*; ();

	logic start;
	// requested direction, high for twist
	logic negative;
	logic done;
	primeMask_t mask;
	logic empty;

	modport ctrl (
		output start,
		output negative,
		input  done,
		input  mask,
		input  empty
	);

	modport unit (
		input  start,
		input  negative,
		output done,
		output mask,
		output empty
	);

endinterface

/* hdl/wordSerialScaler.sv */
`timescale 1ns/1ps

module wordSerialScaler import csidhPkg::*; #(
	parameter int LimbWidth = $bits(limb_t)
) (
	input logic clk,
	input logic rst,
	scaleIf.unit scale
);

	localparam int FieldBits = $bits(fieldWord_t);
	localparam int PrimeBits = $bits(smallPrime_t);
	localparam int Limbs = FieldBits / LimbWidth;
	localparam int CountBits = $clog2(Limbs + 1);

	fieldWord_t operandReg;
	fieldWord_t productReg;
	smallPrime_t factorReg;
	logic [PrimeBits-1:0] carry;
	logic [LimbWidth+PrimeBits-1:0] partial;
	logic [CountBits-1:0] limbCount;
	logic running;
	logic doneReg;

	// lowest remaining limb times the prime, plus overflow of the previous limb
	assign partial = operandReg[LimbWidth-1:0] * factorReg + carry;

	// --------------------
	// sequencing
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			doneReg <= 1'b0;
			limbCount <= '0;
		end else begin
			doneReg <= 1'b0;
			if (!running && scale.start) begin
				running <= 1'b1;
				limbCount <= '0;
			end else if (running) begin
				limbCount <= limbCount + 1'b1;
				if (limbCount == CountBits'(Limbs - 1)) begin
					running <= 1'b0;
					doneReg <= 1'b1;
				end
			end
		end
	end

	// --------------------
	// datapath
	// --------------------
	always_ff @(posedge clk) begin
		if (!running && scale.start) begin
			operandReg <= scale.operand;
			factorReg <= scale.factor;
			carry <= '0;
		end else if (running) begin
			operandReg <= operandReg >> LimbWidth;
			// result limbs enter from the top, final carry falls off
			productReg <= (productReg >> LimbWidth) |
				(fieldWord_t'(partial[LimbWidth-1:0]) << (FieldBits - LimbWidth));
			carry <= partial[LimbWidth+PrimeBits-1:LimbWidth];
		end
	end

	assign scale.product = productReg;
	assign scale.done = doneReg;

endmodule

/* test/csidhSchedulerTb.sv */
`timescale 1ns/1ps
`include "csidh_macros.svh"

module csidhSchedulerTb import csidhPkg::*; ();

	localparam int clkPeriod = 20;
	localparam int numTests = 4;
	localparam int numPrimes = `CSIDH_NUM_PRIMES;
	localparam longint timeoutCycles = longint'(numTests) * numPrimes * 20 * 40;

	logic clk;
	logic rst;
	logic start;
	privateKey_t privateKey;
	logic batchValid;
	logic batchReady;
	primeMask_t resultMask;
	primeMask_t batchMask;
	fieldWord_t batchScalar;
	logic batchNegative;
	logic busy;
	logic done;

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	logic [31:0] rngState = 32'd93360;

	// model state
	int primes [numPrimes];
	logic [3:0] codes [numPrimes];
	bit modelNeg;

	csidhScheduler csidhScheduler_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.privateKey(privateKey),
		.batchValid(batchValid),
		.batchReady(batchReady),
		.resultMask(resultMask),
		.batchMask(batchMask),
		.batchScalar(batchScalar),
		.batchNegative(batchNegative),
		.busy(busy),
		.done(done)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// --------------------
	// protocol properties
	// --------------------
	holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
		(batchValid && !batchReady) |=> (batchValid && $stable(batchMask) &&
			$stable(batchScalar) && $stable(batchNegative)))
	else begin
		errorCount++;
		$display("error at time %0t: batch changed while the consumer stalled", $time);
	end

	doneExcludesBusy: assert property (@(posedge clk) disable iff (rst) !(done && busy))
	else begin
		errorCount++;
		$display("error at time %0t: done and busy high together", $time);
	end

	offerNeedsBusy: assert property (@(posedge clk) disable iff (rst) batchValid |-> busy)
	else begin
		errorCount++;
		$display("error at time %0t: batch offered while not busy", $time);
	end

	// --------------------
	// helpers
	// --------------------
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic bit isOddPrime(input int n);
		for (int d = 3; d * d <= n; d += 2) begin
			if (n % d == 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// lowest indices first, at most one batch worth
	function automatic primeMask_t modelSelect(input bit neg);
		primeMask_t m;
		int taken;
		m = '0;
		taken = 0;
		for (int i = 0; i < numPrimes; i++) begin
			if (taken < `CSIDH_BATCH_MAX && codes[i][3] == neg && codes[i][2:0] != 3'd0) begin
				m[i] = 1'b1;
				taken++;
			end
		end
		return m;
	endfunction

	// empty result means both directions are spent
	function automatic primeMask_t modelNextBatch();
		primeMask_t m;
		m = modelSelect(modelNeg);
		if (m == '0 && !modelNeg) begin
			modelNeg = 1'b1;
			m = modelSelect(1'b1);
		end
		return m;
	endfunction

	function automatic fieldWord_t modelScalar(input primeMask_t m);
		fieldWord_t k;
		k = fieldWord_t'(4);
		for (int i = 0; i < numPrimes; i++) begin
			if (!m[i]) begin
				k = k * fieldWord_t'(primes[i]);
			end
		end
		return k;
	endfunction

	function automatic privateKey_t randomKey();
		privateKey_t key;
		logic [31:0] draw;
		key = '0;
		for (int i = 0; i < numPrimes; i++) begin
			draw = nextRand();
			key[4*i +: 4] = draw[3:0];
		end
		return key;
	endfunction

	task automatic expectTrue(input bit cond, input string what);
		checkCount++;
		assert (cond) else begin
			errorCount++;
			$display("error at time %0t: %s", $time, what);
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// --------------------
	// one key from start to done
	// --------------------
	task automatic runTest(input string name, input privateKey_t key, input bit stalls,
		input bit partial, input int expBatches);
		int batches;
		int startErrors;
		bit offerSeen;
		primeMask_t expMask;
		primeMask_t result;
		bit ready;
		logic [31:0] draw;
		batches = 0;
		startErrors = errorCount;
		offerSeen = 1'b0;
		expMask = '0;
		for (int i = 0; i < numPrimes; i++) begin
			codes[i] = key[4*(numPrimes-1-i) +: 4];
		end
		modelNeg = 1'b0;
		start = 1'b1;
		privateKey = key;
		nextCycle();
		start = 1'b0;
		while (!done) begin
			expectTrue(busy, "busy low while a key is in progress");
			batchReady = 1'b0;
			if (batchValid) begin
				if (!offerSeen) begin
					offerSeen = 1'b1;
					batches++;
					expMask = modelNextBatch();
					expectTrue(expMask != '0, "batch offered with no exponent left in the model");
					expectTrue(batchMask == expMask, "batch mask differs from the model");
					expectTrue(batchNegative == modelNeg, "batch direction differs from the model");
					expectTrue(batchScalar == modelScalar(expMask), "batch scalar is wrong");
				end
				if (stalls) begin
					draw = nextRand();
					ready = (draw[1:0] != 2'd0);
				end else begin
					ready = 1'b1;
				end
				result = '1;
				if (partial) begin
					for (int i = 0; i < numPrimes; i++) begin
						draw = nextRand();
						result[i] = (draw[1:0] != 2'd0);
					end
				end
				batchReady = ready;
				resultMask = result;
				if (ready) begin
					for (int i = 0; i < numPrimes; i++) begin
						if (expMask[i] && result[i] && codes[i][2:0] != 3'd0) begin
							codes[i] = {codes[i][3], codes[i][2:0] - 3'd1};
						end
					end
					offerSeen = 1'b0;
				end
			end
			nextCycle();
		end
		batchReady = 1'b0;
		expectTrue(!busy, "busy still high with done");
		expectTrue(modelNextBatch() == '0, "done while the model still has exponents");
		if (expBatches >= 0) begin
			expectTrue(batches == expBatches, "unexpected number of batches");
		end
		testCount++;
		$display("test %s finished: %0d batches, %0d errors", name, batches,
			errorCount - startErrors);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		privateKey_t key;
		int n;
		int idx;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		privateKey = '0;
		batchReady = 1'b0;
		resultMask = '0;

		// odd primes from 3 up, 587 closes the table
		n = 3;
		idx = 0;
		while (idx < numPrimes - 1) begin
			if (isOddPrime(n)) begin
				primes[idx] = n;
				idx++;
			end
			n += 2;
		end
		primes[numPrimes-1] = 587;

		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		expectTrue(!batchValid && !busy && !done, "outputs not idle after reset");
		nextCycle();

		runTest("a zero key", '0, 1'b0, 1'b0, 0);

		key = '0;
		key[4*(numPrimes-1-5) +: 4] = 4'h3;
		runTest("b single prime", key, 1'b0, 1'b0, 3);

		runTest("c mixed key", randomKey(), 1'b0, 1'b0, -1);
		runTest("d stalls and partial results", randomKey(), 1'b1, 1'b1, -1);

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(timeoutCycles * clkPeriod);
		$display("the run timed out before all tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hdl
hdl/csidhPkg.sv
hdl/scaleIf.sv
hdl/selectIf.sv
hdl/exponentBank.sv
hdl/wordSerialScaler.sv
hdl/batchSelector.sv
hdl/roundControl.sv
hdl/csidhScheduler.sv
test/csidhSchedulerTb.sv
